//--- logic/axi4lite_dist_pkg.sv
`default_nettype none

package axi4lite_dist_pkg;

    // ----------------------------------------------------------
    // Bus geometry
    // ----------------------------------------------------------
    localparam int unsigned ADDR_W    = 32;
    localparam int unsigned DATA_W    = 32;
    localparam int unsigned STRB_W    = 4;
    localparam int unsigned RESP_W    = 2;

    // Port decode, address bits 25:24 pick one of four slaves
    localparam int unsigned NUM_PORTS = 4;
    localparam int unsigned SEL_W     = 2;
    localparam int unsigned SEL_LSB   = 24;

    localparam logic [RESP_W-1:0] RESP_OKAY = 2'b00;

    typedef logic [SEL_W-1:0] port_sel_t;

    // ----------------------------------------------------------
    // Read channels
    // ----------------------------------------------------------
    // Master to slave, AR plus rready
    typedef struct packed {
        logic              arvalid;
        logic [ADDR_W-1:0] araddr;
        logic              rready;
    } rd_req_t;

    // Slave to master, arready plus R
    typedef struct packed {
        logic              arready;
        logic              rvalid;
        logic [DATA_W-1:0] rdata;
        logic [RESP_W-1:0] rresp;
    } rd_rsp_t;

    // ----------------------------------------------------------
    // Write channels
    // ----------------------------------------------------------
    typedef struct packed {
        logic              awvalid;
        logic [ADDR_W-1:0] awaddr;
        logic              wvalid;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] wstrb;
        logic              bready;
    } wr_req_t;

    typedef struct packed {
        logic              awready;
        logic              wready;
        logic              bvalid;
        logic [RESP_W-1:0] bresp;
    } wr_rsp_t;

endpackage

`default_nettype wire

//--- logic/dist_read_path.sv
`default_nettype none

module dist_read_path
    import axi4lite_dist_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_i,
    input  rd_req_t mst_req_i,
    output rd_rsp_t mst_rsp_o,
    output rd_req_t slv_req_o [NUM_PORTS],
    input  rd_rsp_t slv_rsp_i [NUM_PORTS]
);

    port_sel_t            read_sel_q;
    port_sel_t            read_sel_r;
    logic                 read_pending_q;
    logic                 ar_fire;
    logic                 r_fire;
    logic [NUM_PORTS-1:0] port_arvalid;

    // ----------------------------------------------------------
    // Port select
    // ----------------------------------------------------------
    // Live decode while idle, registered port once AR is taken
    assign read_sel_r = read_pending_q ? read_sel_q : mst_req_i.araddr[SEL_LSB +: SEL_W];

    assign ar_fire = mst_req_i.arvalid && mst_rsp_o.arready;
    assign r_fire  = mst_rsp_o.rvalid && mst_req_i.rready;

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            read_pending_q <= 1'b0;
            read_sel_q     <= '0;
        end
        else if (r_fire)
        begin
            read_pending_q <= 1'b0;
        end
        else if (ar_fire)
        begin
            read_pending_q <= 1'b1;
            read_sel_q     <= read_sel_r;
        end
    end

    // ----------------------------------------------------------
    // AR fan-out and rready steering
    // ----------------------------------------------------------
    always_comb
    begin
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            port_arvalid[i] = mst_req_i.arvalid && !read_pending_q
                              && (read_sel_r == port_sel_t'(i));

            slv_req_o[i].arvalid = port_arvalid[i];
            // Address goes to every port, only valid is steered
            slv_req_o[i].araddr  = mst_req_i.araddr;
            slv_req_o[i].rready  = mst_req_i.rready && read_pending_q
                                   && (read_sel_q == port_sel_t'(i));
        end
    end

    // ----------------------------------------------------------
    // Master-side response mux
    // ----------------------------------------------------------
    always_comb
    begin
        // One read in flight, so hold off AR until R is done
        mst_rsp_o.arready = slv_rsp_i[read_sel_r].arready && !read_pending_q;

        mst_rsp_o.rvalid  = slv_rsp_i[read_sel_q].rvalid && read_pending_q;
        mst_rsp_o.rdata   = slv_rsp_i[read_sel_q].rdata;
        mst_rsp_o.rresp   = slv_rsp_i[read_sel_q].rresp;
    end

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------
    // Registered port must not move until the R transfer
    a_read_sel_stable: assert property (
        @(posedge clk_i) disable iff (rst_i)
        read_pending_q |=> $stable(read_sel_q)
    );

    // No port sees an AR while a read is in flight
    a_no_ar_while_pending: assert property (
        @(posedge clk_i) disable iff (rst_i)
        read_pending_q |-> (port_arvalid == '0)
    );

endmodule

`default_nettype wire

//--- logic/dist_write_path.sv
`default_nettype none

module dist_write_path
    import axi4lite_dist_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_i,
    input  wr_req_t mst_req_i,
    output wr_rsp_t mst_rsp_o,
    output wr_req_t slv_req_o [NUM_PORTS],
    input  wr_rsp_t slv_rsp_i [NUM_PORTS]
);

    port_sel_t            write_sel_q;
    port_sel_t            write_sel_r;
    logic                 write_pending_q;
    logic                 aw_held_q;
    logic                 w_held_q;
    logic                 aw_fire;
    logic                 w_fire;
    logic                 b_fire;
    logic                 cmd_done;
    logic                 data_done;
    logic                 aw_open;
    logic                 w_open;
    logic [NUM_PORTS-1:0] port_awvalid;
    logic [NUM_PORTS-1:0] port_wvalid;

    // ----------------------------------------------------------
    // Channel gating
    // ----------------------------------------------------------
    // AW may pass once per write
    assign aw_open = !aw_held_q && !write_pending_q;

    // W only follows an address that is present or already taken
    assign w_open  = !w_held_q && !write_pending_q && (mst_req_i.awvalid || aw_held_q);

    // New decode only while the address is still on the master bus
    always_comb
    begin
        write_sel_r = write_sel_q;
        if (mst_req_i.awvalid && aw_open)
            write_sel_r = mst_req_i.awaddr[SEL_LSB +: SEL_W];
    end

    assign aw_fire   = mst_req_i.awvalid && mst_rsp_o.awready;
    assign w_fire    = mst_req_i.wvalid && mst_rsp_o.wready;
    assign b_fire    = mst_rsp_o.bvalid && mst_req_i.bready;

    // Each half counts as done if taken now or on an earlier edge
    assign cmd_done  = aw_fire || aw_held_q;
    assign data_done = w_fire || w_held_q;

    // ----------------------------------------------------------
    // AW/W tracking and pending state
    // ----------------------------------------------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            aw_held_q       <= 1'b0;
            w_held_q        <= 1'b0;
            write_pending_q <= 1'b0;
            write_sel_q     <= '0;
        end
        else
        begin
            write_sel_q <= write_sel_r;

            if (cmd_done && data_done)
            begin
                aw_held_q       <= 1'b0;
                w_held_q        <= 1'b0;
                write_pending_q <= 1'b1;
            end
            else
            begin
                if (aw_fire)
                    aw_held_q <= 1'b1;
                if (w_fire)
                    w_held_q <= 1'b1;
                if (b_fire)
                    write_pending_q <= 1'b0;
            end
        end
    end

    // ----------------------------------------------------------
    // AW/W fan-out and bready steering
    // ----------------------------------------------------------
    always_comb
    begin
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            port_awvalid[i] = mst_req_i.awvalid && aw_open && (write_sel_r == port_sel_t'(i));
            port_wvalid[i]  = mst_req_i.wvalid && w_open && (write_sel_r == port_sel_t'(i));

            slv_req_o[i].awvalid = port_awvalid[i];
            slv_req_o[i].awaddr  = mst_req_i.awaddr;
            slv_req_o[i].wvalid  = port_wvalid[i];
            slv_req_o[i].wdata   = mst_req_i.wdata;
            slv_req_o[i].wstrb   = mst_req_i.wstrb;
            slv_req_o[i].bready  = mst_req_i.bready && write_pending_q
                                   && (write_sel_q == port_sel_t'(i));
        end
    end

    // ----------------------------------------------------------
    // Master-side response mux
    // ----------------------------------------------------------
    always_comb
    begin
        mst_rsp_o.awready = slv_rsp_i[write_sel_r].awready && aw_open;
        mst_rsp_o.wready  = slv_rsp_i[write_sel_r].wready && w_open;

        // B comes from the port registered with the write
        mst_rsp_o.bvalid  = slv_rsp_i[write_sel_q].bvalid && write_pending_q;
        mst_rsp_o.bresp   = slv_rsp_i[write_sel_q].bresp;
    end

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------
    // A held AW and a held W always merge into pending
    a_held_exclusive: assert property (
        @(posedge clk_i) disable iff (rst_i)
        !(aw_held_q && w_held_q)
    );

    // Port is fixed from AW acceptance through the B transfer
    a_write_sel_stable: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (aw_held_q || write_pending_q) |=> $stable(write_sel_q)
    );

endmodule

`default_nettype wire

//--- logic/axi4lite_dist.sv
`default_nettype none

module axi4lite_dist
    import axi4lite_dist_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_i,

    // Master side
    input  rd_req_t inport_rd_i,
    output rd_rsp_t inport_rd_o,
    input  wr_req_t inport_wr_i,
    output wr_rsp_t inport_wr_o,

    // Slave side, one entry per port
    output rd_req_t outport_rd_o [NUM_PORTS],
    input  rd_rsp_t outport_rd_i [NUM_PORTS],
    output wr_req_t outport_wr_o [NUM_PORTS],
    input  wr_rsp_t outport_wr_i [NUM_PORTS]
);

    // ----------------------------------------------------------
    // Read direction
    // ----------------------------------------------------------
    // AR routed by address, R returned from the port that took it
    dist_read_path u_read_path
    (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .mst_req_i (inport_rd_i),
        .mst_rsp_o (inport_rd_o),
        .slv_req_o (outport_rd_o),
        .slv_rsp_i (outport_rd_i)
    );

    // ----------------------------------------------------------
    // Write direction
    // ----------------------------------------------------------
    // AW and W steered together, B returned from the same port.
    // Runs independently of the read side.
    dist_write_path u_write_path
    (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .mst_req_i (inport_wr_i),
        .mst_rsp_o (inport_wr_o),
        .slv_req_o (outport_wr_o),
        .slv_rsp_i (outport_wr_i)
    );

endmodule

`default_nettype wire

//--- tests/tb_axi4lite_dist.sv
`default_nettype none

module tb_axi4lite_dist
    import axi4lite_dist_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    logic    clk_i;
    logic    rst_i;
    rd_req_t mst_rd;
    rd_rsp_t mst_rd_rsp;
    wr_req_t mst_wr;
    wr_rsp_t mst_wr_rsp;
    rd_req_t slv_rd_req [NUM_PORTS];
    rd_rsp_t slv_rd_rsp [NUM_PORTS];
    wr_req_t slv_wr_req [NUM_PORTS];
    wr_rsp_t slv_wr_rsp [NUM_PORTS];

    logic [135:0] trace_mem [0:63];
    logic [15:0]  lfsr_q = 16'd9;
    int           num_lines;
    int           cycle_cnt;
    int           cycle_limit;

    // Slave model state, one entry per port
    int          ar_cnt [NUM_PORTS];
    int          r_cnt  [NUM_PORTS];
    int          aw_cnt [NUM_PORTS];
    int          w_cnt  [NUM_PORTS];
    int          b_cnt  [NUM_PORTS];
    logic [31:0] got_raddr [NUM_PORTS];
    logic [31:0] got_waddr [NUM_PORTS];
    logic [31:0] got_wdata [NUM_PORTS];
    logic [3:0]  got_strb  [NUM_PORTS];
    bit          ar_take [NUM_PORTS];
    bit          r_take  [NUM_PORTS];
    bit          aw_take [NUM_PORTS];
    bit          w_take  [NUM_PORTS];
    bit          b_take  [NUM_PORTS];
    bit          rd_active [NUM_PORTS];
    bit          aw_got    [NUM_PORTS];
    bit          w_got     [NUM_PORTS];
    bit          b_active  [NUM_PORTS];
    int          rd_delay  [NUM_PORTS];
    int          b_delay   [NUM_PORTS];
    logic [31:0] cur_rdata;
    logic [1:0]  cur_resp;
    bit          rd_busy;
    bit          wr_busy;

    axi4lite_dist u_axi4lite_dist
    (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .inport_rd_i  (mst_rd),
        .inport_rd_o  (mst_rd_rsp),
        .inport_wr_i  (mst_wr),
        .inport_wr_o  (mst_wr_rsp),
        .outport_rd_o (slv_rd_req),
        .outport_rd_i (slv_rd_rsp),
        .outport_wr_o (slv_wr_req),
        .outport_wr_i (slv_wr_rsp)
    );

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------
    // Galois LFSR, taps 16,14,13,11
    function automatic logic take_bit();
        logic b;
        b = lfsr_q[0];
        lfsr_q = b ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
        return b;
    endfunction

    function automatic int take_delay();
        logic [1:0] d;
        d[0] = take_bit();
        d[1] = take_bit();
        return int'(d);
    endfunction

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        assert (exp === act)
        else
        begin
            $display("CHECK FAILED %s expected %0h actual %0h", name, exp, act);
            $display("test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic clear_counts();
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            ar_cnt[p] = 0;
            r_cnt[p]  = 0;
            aw_cnt[p] = 0;
            w_cnt[p]  = 0;
            b_cnt[p]  = 0;
        end
    endtask

    // ----------------------------------------------------------
    // Clock, timeout
    // ----------------------------------------------------------
    initial
    begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    always @(posedge clk_i)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit)
            stop_with_failure("timeout, DUT did not respond");
    end

    // ----------------------------------------------------------
    // Slave models
    // ----------------------------------------------------------
    // Sample at the falling edge where everything has settled
    always
    begin
        @(negedge clk_i);
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            ar_take[p] = slv_rd_req[p].arvalid && slv_rd_rsp[p].arready;
            r_take[p]  = slv_rd_rsp[p].rvalid && slv_rd_req[p].rready;
            aw_take[p] = slv_wr_req[p].awvalid && slv_wr_rsp[p].awready;
            w_take[p]  = slv_wr_req[p].wvalid && slv_wr_rsp[p].wready;
            b_take[p]  = slv_wr_rsp[p].bvalid && slv_wr_req[p].bready;
            assert (!(rd_busy && slv_rd_req[p].arvalid))
            else
                stop_with_failure("second AR reached a port while a read was pending");
            assert (!(wr_busy && slv_wr_req[p].awvalid))
            else
                stop_with_failure("second AW reached a port while a write was pending");
            if (ar_take[p])
            begin
                ar_cnt[p]++;
                got_raddr[p] = slv_rd_req[p].araddr;
            end
            if (r_take[p])
                r_cnt[p]++;
            if (aw_take[p])
            begin
                aw_cnt[p]++;
                got_waddr[p] = slv_wr_req[p].awaddr;
            end
            if (w_take[p])
            begin
                w_cnt[p]++;
                got_wdata[p] = slv_wr_req[p].wdata;
                got_strb[p]  = slv_wr_req[p].wstrb;
            end
            if (b_take[p])
                b_cnt[p]++;
        end
        @(posedge clk_i);
        #2;
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            slv_rd_rsp[p].arready = take_bit();
            slv_wr_rsp[p].awready = take_bit();
            slv_wr_rsp[p].wready  = take_bit();

            // Read side
            if (r_take[p])
                slv_rd_rsp[p].rvalid = 1'b0;
            if (ar_take[p])
            begin
                rd_active[p] = 1'b1;
                rd_delay[p]  = take_delay();
            end
            else if (rd_active[p])
            begin
                if (rd_delay[p] == 0)
                begin
                    slv_rd_rsp[p].rvalid = 1'b1;
                    slv_rd_rsp[p].rdata  = cur_rdata;
                    slv_rd_rsp[p].rresp  = cur_resp;
                    rd_active[p] = 1'b0;
                end
                else
                    rd_delay[p]--;
            end

            // Write side answers once both halves arrived
            if (b_take[p])
                slv_wr_rsp[p].bvalid = 1'b0;
            if (aw_take[p])
                aw_got[p] = 1'b1;
            if (w_take[p])
                w_got[p] = 1'b1;
            if (aw_got[p] && w_got[p])
            begin
                aw_got[p]   = 1'b0;
                w_got[p]    = 1'b0;
                b_active[p] = 1'b1;
                b_delay[p]  = take_delay();
            end
            else if (b_active[p])
            begin
                if (b_delay[p] == 0)
                begin
                    slv_wr_rsp[p].bvalid = 1'b1;
                    slv_wr_rsp[p].bresp  = cur_resp;
                    b_active[p] = 1'b0;
                end
                else
                    b_delay[p]--;
            end
        end
    end

    // ----------------------------------------------------------
    // Master transactions
    // ----------------------------------------------------------
    task automatic run_read(input logic [31:0] addr, input port_sel_t port);
        bit          ar_done;
        bit          r_done;
        bit          seen;
        logic [33:0] held;
        logic [33:0] got;
        ar_done = 1'b0;
        r_done  = 1'b0;
        seen    = 1'b0;
        held    = '0;
        got     = '0;
        mst_rd.araddr  = addr;
        mst_rd.arvalid = 1'b1;
        while (!ar_done)
        begin
            @(negedge clk_i);
            ar_done = mst_rd_rsp.arready;
            @(posedge clk_i);
            #2;
        end
        // Request stays up while R is outstanding and must not reach a port
        rd_busy = 1'b1;
        while (!r_done)
        begin
            mst_rd.rready = take_bit();
            @(negedge clk_i);
            if (mst_rd_rsp.rvalid)
            begin
                got = {mst_rd_rsp.rresp, mst_rd_rsp.rdata};
                if (seen)
                    check_value("read data held", 64'(held), 64'(got));
                held = got;
                seen = 1'b1;
                r_done = mst_rd.rready;
            end
            @(posedge clk_i);
            #2;
        end
        mst_rd.arvalid = 1'b0;
        mst_rd.rready = 1'b0;
        rd_busy = 1'b0;
        check_value("read rdata", 64'(cur_rdata), 64'(got[31:0]));
        check_value("read rresp", 64'(cur_resp), 64'(got[33:32]));
        repeat (2) @(posedge clk_i);
        #2;
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            check_value("read AR count", (p == int'(port)) ? 64'd1 : 64'd0, 64'(ar_cnt[p]));
            check_value("read R count", (p == int'(port)) ? 64'd1 : 64'd0, 64'(r_cnt[p]));
        end
        check_value("read address", 64'(addr), 64'(got_raddr[port]));
    endtask

    task automatic run_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic [3:0] lead,
                             input port_sel_t port);
        bit aw_done;
        bit w_done;
        bit aw_now;
        bit w_now;
        bit b_done;
        int cyc;
        aw_done = 1'b0;
        w_done  = 1'b0;
        b_done  = 1'b0;
        cyc     = 0;
        mst_wr.awaddr  = addr;
        mst_wr.wdata   = data;
        mst_wr.wstrb   = strb;
        mst_wr.awvalid = (lead != 4'd1);
        mst_wr.wvalid  = (lead != 4'd2);
        while (!(aw_done && w_done))
        begin
            @(negedge clk_i);
            aw_now = mst_wr.awvalid && mst_wr_rsp.awready;
            w_now  = mst_wr.wvalid && mst_wr_rsp.wready;
            @(posedge clk_i);
            #2;
            cyc++;
            if (aw_now)
            begin
                aw_done = 1'b1;
                mst_wr.awvalid = 1'b0;
            end
            if (w_now)
            begin
                w_done = 1'b1;
                mst_wr.wvalid = 1'b0;
            end
            // W first holds data alone for two cycles
            if (lead == 4'd1 && cyc == 2 && !aw_done)
                mst_wr.awvalid = 1'b1;
            if (lead == 4'd2 && aw_done && !w_done)
                mst_wr.wvalid = 1'b1;
        end
        // A new address stays up while B is outstanding and must not reach a port
        mst_wr.awvalid = 1'b1;
        wr_busy = 1'b1;
        while (!b_done)
        begin
            mst_wr.bready = take_bit();
            @(negedge clk_i);
            if (mst_wr_rsp.bvalid)
            begin
                check_value("write bresp", 64'(cur_resp), 64'(mst_wr_rsp.bresp));
                b_done = mst_wr.bready;
            end
            @(posedge clk_i);
            #2;
        end
        mst_wr.awvalid = 1'b0;
        mst_wr.bready = 1'b0;
        wr_busy = 1'b0;
        repeat (2) @(posedge clk_i);
        #2;
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            check_value("write AW count", (p == int'(port)) ? 64'd1 : 64'd0, 64'(aw_cnt[p]));
            check_value("write W count", (p == int'(port)) ? 64'd1 : 64'd0, 64'(w_cnt[p]));
            check_value("write B count", (p == int'(port)) ? 64'd1 : 64'd0, 64'(b_cnt[p]));
        end
        check_value("write address", 64'(addr), 64'(got_waddr[port]));
        check_value("write data", 64'(data), 64'(got_wdata[port]));
        check_value("write strobe", 64'(strb), 64'(got_strb[port]));
    endtask

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial
    begin
        logic [135:0] line;
        port_sel_t    port;
        rst_i     = 1'b1;
        mst_rd    = '0;
        mst_wr    = '0;
        rd_busy   = 1'b0;
        wr_busy   = 1'b0;
        cycle_cnt = 0;
        cur_rdata = '0;
        cur_resp  = RESP_OKAY;
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            slv_rd_rsp[p] = '0;
            slv_wr_rsp[p] = '0;
            rd_active[p]  = 1'b0;
            aw_got[p]     = 1'b0;
            w_got[p]      = 1'b0;
            b_active[p]   = 1'b0;
        end
        clear_counts();
        for (int i = 0; i < 64; i++)
            trace_mem[i] = '1;
        $readmemh("tests/dist_trace.txt", trace_mem);
        num_lines = 0;
        while (num_lines < 64 && trace_mem[num_lines][135:132] != 4'hf)
            num_lines++;
        cycle_limit = num_lines * 64 + 5 + 4;

        repeat (5) @(posedge clk_i);
        #2;
        rst_i = 1'b0;

        // Idle state after reset
        @(negedge clk_i);
        check_value("reset rvalid", 64'd0, 64'(mst_rd_rsp.rvalid));
        check_value("reset bvalid", 64'd0, 64'(mst_wr_rsp.bvalid));
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            check_value("reset port valids", 64'd0,
                        64'({slv_rd_req[p].arvalid, slv_wr_req[p].awvalid,
                             slv_wr_req[p].wvalid}));
        end
        @(posedge clk_i);
        #2;

        for (int i = 0; i < num_lines; i++)
        begin
            line = trace_mem[i];
            port = line[53:52];
            check_value("trace port decode", 64'(line[121:120]), 64'(port));
            cur_rdata = line[47:16];
            cur_resp  = line[57:56];
            clear_counts();
            if (line[135:132] == 4'd0)
                run_read(line[127:96], port);
            else
                run_write(line[127:96], line[95:64], line[63:60], line[131:128], port);
        end

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- axi4lite_dist.f
logic/axi4lite_dist_pkg.sv
logic/dist_read_path.sv
logic/dist_write_path.sv
logic/axi4lite_dist.sv
tests/tb_axi4lite_dist.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the axi4lite_dist testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    --top-module tb_axi4lite_dist \
    -f axi4lite_dist.f \
    -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "test failed" "$LOG"; then
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

exit 0

//--- tests/dist_trace.txt
// op(0 rd,1 wr)_lead(0 both,1 W first,2 AW first)_addr_wdata_strb_resp_port_0
//   _slave rdata_0000
0_0_00000100_00000000_0_0_0_0_a5a50001_0000
0_0_01000204_00000000_0_0_1_0_11112222_0000
0_0_02000008_00000000_0_2_2_0_33334444_0000
0_0_03fffffc_00000000_0_0_3_0_deadbeef_0000
1_0_00000010_cafe0001_f_0_0_0_00000000_0000
1_1_01000020_cafe0002_3_0_1_0_00000000_0000
1_2_02000030_cafe0003_c_2_2_0_00000000_0000
1_0_03000040_cafe0004_1_3_3_0_00000000_0000
0_0_0d000050_00000000_0_0_1_0_55aa55aa_0000
0_0_0e000054_00000000_0_3_2_0_01234567_0000
1_1_0f000058_12345678_f_0_3_0_00000000_0000
1_2_0c00005c_9abcdef0_6_0_0_0_00000000_0000
0_0_fc000000_00000000_0_0_0_0_89abcdef_0000
0_0_fd000004_00000000_0_1_1_0_fedcba98_0000
1_0_fe000008_0f0f0f0f_a_1_2_0_00000000_0000
1_1_ff00000c_f0f0f0f0_5_0_3_0_00000000_0000
1_2_00ffff00_00000001_8_0_0_0_00000000_0000
0_0_01ffff04_00000000_0_0_1_0_00000002_0000
1_0_02ffff08_00000003_4_0_2_0_00000000_0000
0_0_03ffff0c_00000000_0_2_3_0_00000004_0000
1_1_10000000_aaaa5555_f_0_0_0_00000000_0000
0_0_11000010_00000000_0_0_1_0_5555aaaa_0000
1_2_12000020_13579bdf_2_3_2_0_00000000_0000
0_0_13000030_00000000_0_0_3_0_2468ace0_0000
1_0_7c000040_ffffffff_f_0_0_0_00000000_0000
1_1_7d000044_00000000_1_2_1_0_00000000_0000
0_0_7e000048_00000000_0_0_2_0_c0ffee00_0000
1_2_7f00004c_76543210_e_0_3_0_00000000_0000
0_0_80000050_00000000_0_1_0_0_0badf00d_0000
1_0_81000054_fedcba98_7_0_1_0_00000000_0000
